/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = microSequencerTb
FILELIST = vlog.f
BIN = obj_dir/V$(TOP)
PASS = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS)'

clean:
	rm -rf obj_dir

/* test/microSequencerTb.sv */
`default_nettype none

module microSequencerTb;
  import kl10SeqPkg::*;

  // About 90 cycles of tests plus reset, with generous margin
  localparam int maxCycles = 400;

  logic eboxClk;
  logic rstN;
  logic force1777;
  logic [0:dramAW-1] dramA;
  logic [0:cramAdrW-1] dramJ;
  logic [0:numFlagGroups-1][0:flagGroupW-1] flagGroups;
  logic [0:numSkipFlags-1] skipFlags;
  logic diagRead;
  logic diagLoad;
  logic [0:diagFuncW-1] diagFunc;
  logic [0:ebusW-1] ebusIn;
  logic [0:cramAdrW-1] cradr;
  logic [0:ucodeDataW-1] ucodeData;
  logic [0:ebusW-1] ebusOut;
  logic ebusDriving;

  // Reference model state
  logic [0:cramWordW-1] rom [cramDepth];
  logic [0:cramAdrW-1] mAdr;
  logic [0:cramAdrW-1] mDiag;
  logic [0:cramAdrW-1] mStack [stackDepth];
  logic [0:stackPtrW-1] mPtr;

  int errors;
  int checks;
  int testErrs;
  int cycles;

  microSequencer DUT (
    .eboxClk(eboxClk),
    .rstN(rstN),
    .force1777(force1777),
    .dramA(dramA),
    .dramJ(dramJ),
    .flagGroups(flagGroups),
    .skipFlags(skipFlags),
    .diagRead(diagRead),
    .diagLoad(diagLoad),
    .diagFunc(diagFunc),
    .ebusIn(ebusIn),
    .cradr(cradr),
    .ucodeData(ucodeData),
    .ebusOut(ebusOut),
    .ebusDriving(ebusDriving)
  );

  initial begin
    eboxClk = 1'b0;
    forever #20 eboxClk = ~eboxClk;
  end

  always @(posedge eboxClk) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("timeout after %0d cycles, tests did not finish", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  task automatic checkAdr(input logic [0:cramAdrW-1] got, input logic [0:cramAdrW-1] exp,
                          input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      testErrs++;
      $display("mismatch at %0t: %s got %04o expected %04o", $time, name, got, exp);
    end
  endtask

  task automatic checkEbus(input logic [0:ebusW-1] got, input logic [0:ebusW-1] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      testErrs++;
      $display("mismatch at %0t: ebusOut got %02o expected %02o", $time, got, exp);
    end
  endtask

  task automatic checkData(input logic [0:ucodeDataW-1] got,
                           input logic [0:ucodeDataW-1] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      testErrs++;
      $display("mismatch at %0t: ucodeData got %02h expected %02h", $time, got, exp);
    end
  endtask

  task automatic checkDriving(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      testErrs++;
      $display("mismatch at %0t: ebusDriving got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic reportTest(input string name);
    $display("%s: %s (%0d errors)", name, (testErrs == 0) ? "ok" : "failed", testErrs);
    testErrs = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model

  function automatic logic [0:ebusW-1] expectedRead(input logic [0:2] sel);
    logic [0:cramWordW-1] w;
    logic [0:cramAdrW-1] top;
    w = rom[mAdr];
    top = mStack[mPtr];
    case (sel)
      3'd0: return {2'b00, mPtr};
      3'd1: return {w[fldCall], w[fldDisp +: dispW]};
      3'd2: return top[5:10];
      3'd3: return {1'b0, top[0:4]};
      3'd4: return mAdr[5:10];
      3'd5: return {1'b0, mAdr[0:4]};
      default: return '0;
    endcase
  endfunction

  // Check the current cycle at the falling edge, then step the model
  task automatic advance;
    logic [0:cramWordW-1] w;
    logic [0:cramAdrW-1] d;
    logic [0:cramAdrW-1] top;
    logic [0:dispW-1] disp;
    logic [0:condW-1] cond;
    logic [0:stackPtrW-1] np;
    @(negedge eboxClk);
    checkAdr(cradr, mAdr, "cradr");
    checkData(ucodeData, rom[mAdr][fldData +: ucodeDataW]);
    checkDriving(ebusDriving, diagRead);
    if (diagRead) begin
      checkEbus(ebusOut, expectedRead(diagFunc[4:6]));
    end else begin
      checkEbus(ebusOut, '0);
    end
    w = rom[mAdr];
    disp = w[fldDisp +: dispW];
    cond = w[fldCond +: condW];
    top = mStack[mPtr];
    d = '0;
    if (disp == dispReturn) begin
      d = top;
    end else if (disp == dispDramJ) begin
      d = dramJ;
    end else if (disp == dispAread) begin
      d = (dramA == 3'b000) ? dramJ : '0;
    end else if (disp == dispDiag) begin
      d = mDiag;
    end else if (disp[0:1] == 2'b01) begin
      d[7:10] = flagGroups[disp[2:4]];
    end
    if (cond[0:2] == 3'b100) begin
      d[10] = d[10] | skipFlags[cond[3:5]];
    end
    np = mPtr;
    if (disp == dispReturn) begin
      np = np - 4'd1;
    end
    if (w[fldCall]) begin
      np = np + 4'd1;
      mStack[np] = mAdr;
    end
    mPtr = force1777 ? '0 : np;
    if (diagLoad && diagFunc == diagLoadHi) begin
      mDiag[0:4] = ebusIn[1:5];
    end
    if (diagLoad && diagFunc == diagLoadLo) begin
      mDiag[5:10] = ebusIn;
    end
    mAdr = force1777 ? '1 : (w[fldJ +: cramAdrW] | d);
    @(posedge eboxClk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  task automatic loadDiag(input logic [0:cramAdrW-1] a);
    diagLoad <= 1'b1;
    diagFunc <= diagLoadHi;
    ebusIn <= {1'b0, a[0:4]};
    advance();
    diagFunc <= diagLoadLo;
    ebusIn <= a[5:10];
    advance();
    diagLoad <= 1'b0;
    diagFunc <= '0;
  endtask

  // Word 3777 dispatches on the diagnostic address
  task automatic enterAt(input logic [0:cramAdrW-1] a);
    loadDiag(a);
    force1777 <= 1'b1;
    advance();
    force1777 <= 1'b0;
    advance();
  endtask

  task automatic readBack(input logic [0:2] sel);
    diagRead <= 1'b1;
    diagFunc <= {4'b0110, sel};
    advance();
    diagRead <= 1'b0;
    diagFunc <= '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests

  task automatic testJumpChain;
    repeat (5) advance();
    reportTest("jump chain");
  endtask

  task automatic testDramDispatch;
    enterAt(11'o0100);
    dramJ <= 11'($urandom);
    repeat (2) advance();
    enterAt(11'o0101);
    dramA <= 3'b000;
    dramJ <= 11'($urandom);
    repeat (2) advance();
    enterAt(11'o0101);
    dramA <= 3'($urandom_range(7, 1));
    repeat (2) advance();
    reportTest("dram and aread dispatch");
  endtask

  task automatic testFlagSkip;
    flagGroups <= $urandom;
    skipFlags <= 8'($urandom);
    enterAt(11'o0200);
    repeat (2) advance();
    enterAt(11'o0201);
    repeat (2) advance();
    reportTest("flag and skip dispatch");
  endtask

  task automatic testNestedCalls;
    enterAt(11'o0400);
    repeat (8) advance();
    reportTest("nested calls");
  endtask

  task automatic testForce;
    enterAt(11'o0400);
    repeat (2) advance();
    readBack(3'd0);
    force1777 <= 1'b1;
    advance();
    force1777 <= 1'b0;
    readBack(3'd0);
    reportTest("force1777");
  endtask

  // Readbacks run through the call chain so every stack top read is written
  task automatic testDiagLoad;
    enterAt(11'o0400);
    advance();
    for (int s = 0; s < 8; s++) begin
      readBack(3'(s));
    end
    reportTest("diagnostic load and readback");
  endtask

  initial begin
    void'($urandom(32'h2e95_83e4));
    rstN = 1'b0;
    force1777 = 1'b0;
    dramA = '0;
    dramJ = '0;
    flagGroups = '0;
    skipFlags = '0;
    diagRead = 1'b0;
    diagLoad = 1'b0;
    diagFunc = '0;
    ebusIn = '0;
    errors = 0;
    checks = 0;
    testErrs = 0;
    cycles = 0;
    for (int i = 0; i < cramDepth; i++) begin
      rom[i] = '0;
    end
    $readmemh(cramImage, rom);
    mAdr = '0;
    mPtr = '0;
    repeat (16) @(posedge eboxClk);
    rstN <= 1'b1;
    testJumpChain();
    testDramDispatch();
    testFlagSkip();
    testNestedCalls();
    testForce();
    testDiagLoad();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/sbrStack_asserts.sv */
`default_nettype none

module sbrStackAsserts (
  input logic eboxClk,
  input logic rstN,
  input logic force1777,
  input logic call,
  input logic pop,
  input logic [0:kl10SeqPkg::stackPtrW-1] stackPtr,
  input logic [0:kl10SeqPkg::cramAdrW-1] cradr
);

  // Force empties the return stack
  assert property (@(posedge eboxClk) disable iff (!rstN) force1777 |=> stackPtr == '0)
    else $error("stack pointer not zero after force1777");

  // Pointer moves up on a call and down on a return
  assert property (@(posedge eboxClk) disable iff (!rstN)
      !force1777 |=> stackPtr == $past(stackPtr) + $past(call) - $past(pop))
    else $error("stack pointer did not follow call and return");

  // Next address is 3777 one cycle later
  assert property (@(posedge eboxClk) disable iff (!rstN) force1777 |=> cradr == '1)
    else $error("cradr not all ones after force1777");

endmodule

bind cra sbrStackAsserts uAsserts (
  .eboxClk(eboxClk),
  .rstN(rstN),
  .force1777(force1777),
  .call(cram.call),
  .pop(isReturn),
  .stackPtr(stackPtr),
  .cradr(cradr)
);

`default_nettype wire

/* test/ucode.hex */
// Microwords, 31 bits: J(11) DISP(5) COND(6) CALL(1) data(8), J leftmost
// Addresses are hex; octal address in each comment
@000 00100011 // 0000 J=0001
@001 00200012 // 0001 J=0002
@002 00300013 // 0002 J=0003
@003 00300014 // 0003 J=0003 loop
@040 00010000 // 0100 DRAM J dispatch
@041 00018000 // 0101 AREAD dispatch
@080 08058000 // 0200 J=0200 flag group 3
@081 0C004A00 // 0201 J=0300 skip flag 5
@100 14000100 // 0400 call J=0500
@102 10200000 // 0402 J=0402 loop
@140 18000100 // 0500 call J=0600
@141 00208000 // 0501 return J=0002
@180 1C000100 // 0600 call J=0700
@188 00108000 // 0610 return J=0001
@1C0 00808000 // 0700 return J=0010
@7FF 00020000 // 3777 diagnostic address dispatch

/* verilog/cra.sv */
`default_nettype none

module cra (
  input logic eboxClk,
  input logic rstN,
  input logic force1777,
  input logic [0:kl10SeqPkg::dramAW-1] dramA,
  input logic [0:kl10SeqPkg::cramAdrW-1] dramJ,
  input logic [0:kl10SeqPkg::numFlagGroups-1][0:kl10SeqPkg::flagGroupW-1] flagGroups,
  input logic [0:kl10SeqPkg::numSkipFlags-1] skipFlags,
  cramIf.sink cram,
  diagIf diag,
  output logic [0:kl10SeqPkg::cramAdrW-1] cradr,
  output logic [0:kl10SeqPkg::ebusW-1] ebusOut,
  output logic ebusDriving
);
  import kl10SeqPkg::*;

  logic [0:cramAdrW-1] dispBits;
  logic [0:cramAdrW-1] stackTop;
  logic [0:cramAdrW-1] nextAdr;
  logic [0:stackPtrW-1] stackPtr;
  logic [0:ebusW-1] readMux;
  logic isReturn;

  assign isReturn = cram.disp == dispReturn;

  dispatchMux uDispatch (
    .cram(cram),
    .diag(diag),
    .dramA(dramA),
    .dramJ(dramJ),
    .flagGroups(flagGroups),
    .skipFlags(skipFlags),
    .stackTop(stackTop),
    .dispBits(dispBits)
  );

  // Push saves the address of the calling word itself
  sbrStack uStack (
    .eboxClk(eboxClk),
    .rstN(rstN),
    .clear(force1777),
    .push(cram.call),
    .pop(isReturn),
    .pushAdr(cradr),
    .stackTop(stackTop),
    .stackPtr(stackPtr)
  );

  //////////////////////////////////////////////////////////////////////////
  // Next address register

  assign nextAdr = force1777 ? '1 : (cram.j | dispBits);

  always_ff @(posedge eboxClk) begin
    if (!rstN) begin
      cradr <= '0;
    end else begin
      cradr <= nextAdr;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Diagnostic address halves, loaded from EBUS data

  always_ff @(posedge eboxClk) begin
    if (diag.diagLoad && diag.diagFunc == diagLoadHi) begin
      diag.diagAdr[0:4] <= diag.ebusIn[1:5];
    end
    if (diag.diagLoad && diag.diagFunc == diagLoadLo) begin
      diag.diagAdr[5:10] <= diag.ebusIn[0:5];
    end
  end

  // Readback, selected by the low three function bits
  always_comb begin
    readMux = '0;
    case (diag.diagFunc[4:6])
      rdStackPtr: readMux = {{(ebusW - stackPtrW){1'b0}}, stackPtr};
      rdDispField: readMux = {cram.call, cram.disp};
      rdStackTopLo: readMux = stackTop[5:10];
      rdStackTopHi: readMux = {1'b0, stackTop[0:4]};
      rdCradrLo: readMux = cradr[5:10];
      rdCradrHi: readMux = {1'b0, cradr[0:4]};
      default: readMux = '0;
    endcase
  end

  // No tristate, the bus reads zero when not driven
  assign ebusDriving = diag.diagRead;
  assign ebusOut = ebusDriving ? readMux : '0;

endmodule

`default_nettype wire

/* verilog/cramIf.sv */
`default_nettype none

// Decoded microword fields, valid for the word at the current cradr
interface cramIf;
  import kl10SeqPkg::*;

  logic [0:cramAdrW-1] j;
  logic [0:dispW-1] disp;
  logic [0:condW-1] cond;
  logic call;
  logic [0:ucodeDataW-1] ucodeData;

  modport source (
    output j, disp, cond, call, ucodeData
  );

  modport sink (
    input j, disp, cond, call, ucodeData
  );

endinterface

`default_nettype wire

/* verilog/crm.sv */
`default_nettype none

module crm (
  input logic eboxClk,
  input logic [0:kl10SeqPkg::cramAdrW-1] cradr,
  cramIf.source cram
);
  import kl10SeqPkg::*;

  logic [0:cramWordW-1] store [cramDepth];
  logic [0:cramWordW-1] word;

  // Image is sparse, so everything not named in it stays zero
  initial begin
    for (int i = 0; i < cramDepth; i++) begin
      store[i] = '0;
    end
    $readmemh(cramImage, store);
  end

  // Asynchronous read, one microword per eboxClk
  assign word = store[cradr];

  assign cram.j = word[fldJ +: cramAdrW];
  assign cram.disp = word[fldDisp +: dispW];
  assign cram.cond = word[fldCond +: condW];
  assign cram.call = word[fldCall];
  assign cram.ucodeData = word[fldData +: ucodeDataW];

endmodule

`default_nettype wire

/* verilog/diagIf.sv */
`default_nettype none

// Diagnostic strobes, function code and EBUS data into the sequencer
interface diagIf;
  import kl10SeqPkg::*;

  logic diagRead;
  logic diagLoad;
  logic [0:diagFuncW-1] diagFunc;
  logic [0:ebusW-1] ebusIn;
  logic [0:cramAdrW-1] diagAdr;

  // Address logic only needs the latched diagnostic address
  modport sink (
    input diagAdr
  );

endinterface

`default_nettype wire

/* verilog/dispatchMux.sv */
`default_nettype none

module dispatchMux (
  cramIf.sink cram,
  diagIf.sink diag,
  input logic [0:kl10SeqPkg::dramAW-1] dramA,
  input logic [0:kl10SeqPkg::cramAdrW-1] dramJ,
  input logic [0:kl10SeqPkg::numFlagGroups-1][0:kl10SeqPkg::flagGroupW-1] flagGroups,
  input logic [0:kl10SeqPkg::numSkipFlags-1] skipFlags,
  input logic [0:kl10SeqPkg::cramAdrW-1] stackTop,
  output logic [0:kl10SeqPkg::cramAdrW-1] dispBits
);
  import kl10SeqPkg::*;

  logic [0:cramAdrW-1] aread;
  logic [0:cramAdrW-1] dispSel;
  logic flagDisp;
  logic skipEn;
  logic skipBit;

  // AREAD only dispatches when the DRAM A field is zero
  assign aread = (dramA == '0) ? dramJ : '0;

  assign flagDisp = cram.disp[0:1] == dispFlagBase[0:1];
  assign skipEn = cram.cond[0:2] == condSkipBase[0:2];

  //////////////////////////////////////////////////////////////////////////
  // DISP decode

  always_comb begin
    dispSel = '0;
    case (cram.disp)
      dispNone: begin
        dispSel = '0;
      end
      dispReturn: begin
        dispSel = stackTop;
      end
      dispDramJ: begin
        dispSel = dramJ;
      end
      dispAread: begin
        dispSel = aread;
      end
      dispDiag: begin
        dispSel = diag.diagAdr;
      end
      default: begin
        // Flag groups land in the low four address bits
        if (flagDisp) begin
          dispSel[7:10] = flagGroups[cram.disp[2:4]];
        end
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // COND skip, a single bit into address bit 10

  always_comb begin
    skipBit = 1'b0;
    if (skipEn) begin
      skipBit = skipFlags[cram.cond[3:5]];
    end
  end

  assign dispBits = dispSel | {{(cramAdrW - 1){1'b0}}, skipBit};

endmodule

`default_nettype wire

/* verilog/kl10SeqPkg.sv */
`default_nettype none

package kl10SeqPkg;

  // Control store geometry
  localparam int cramAdrW = 11;
  localparam int cramDepth = 2048;
  localparam int cramWordW = 31;
  localparam string cramImage = "test/ucode.hex";

  // Microword layout, bit 0 is the leftmost bit of the hex word
  // J 0..10, DISP 11..15, COND 16..21, CALL 22, datapath field 23..30
  localparam int dispW = 5;
  localparam int condW = 6;
  localparam int ucodeDataW = 8;
  localparam int fldJ = 0;
  localparam int fldDisp = 11;
  localparam int fldCond = 16;
  localparam int fldCall = 22;
  localparam int fldData = 23;

  // Call/return stack
  localparam int stackDepth = 16;
  localparam int stackPtrW = 4;

  // Condition inputs from the rest of the EBOX
  localparam int dramAW = 3;
  localparam int flagGroupW = 4;
  localparam int numFlagGroups = 8;
  localparam int numSkipFlags = 8;

  // Diagnostic bus
  localparam int diagFuncW = 7;
  localparam int ebusW = 6;

  //////////////////////////////////////////////////////////////////////////
  // Field encodings, all octal as in the microcode listings

  localparam logic [0:dispW-1] dispNone = 5'o00;
  localparam logic [0:dispW-1] dispReturn = 5'o01;
  localparam logic [0:dispW-1] dispDramJ = 5'o02;
  localparam logic [0:dispW-1] dispAread = 5'o03;
  localparam logic [0:dispW-1] dispDiag = 5'o04;
  // 10..17, low three bits pick the flag group
  localparam logic [0:dispW-1] dispFlagBase = 5'o10;

  // 40..47, low three bits pick the skip flag
  localparam logic [0:condW-1] condSkipBase = 6'o40;

  localparam logic [0:diagFuncW-1] diagLoadHi = 7'o051;
  localparam logic [0:diagFuncW-1] diagLoadLo = 7'o052;

  // Readback selections on diagFunc[4:6]
  localparam logic [0:2] rdStackPtr = 3'd0;
  localparam logic [0:2] rdDispField = 3'd1;
  localparam logic [0:2] rdStackTopLo = 3'd2;
  localparam logic [0:2] rdStackTopHi = 3'd3;
  localparam logic [0:2] rdCradrLo = 3'd4;
  localparam logic [0:2] rdCradrHi = 3'd5;
  localparam logic [0:2] rdCradrLoAlt = 3'd6;
  localparam logic [0:2] rdCradrHiAlt = 3'd7;

endpackage

`default_nettype wire

/* verilog/microSequencer.sv */
`default_nettype none

module microSequencer (
  input logic eboxClk,
  input logic rstN,
  input logic force1777,
  input logic [0:kl10SeqPkg::dramAW-1] dramA,
  input logic [0:kl10SeqPkg::cramAdrW-1] dramJ,
  input logic [0:kl10SeqPkg::numFlagGroups-1][0:kl10SeqPkg::flagGroupW-1] flagGroups,
  input logic [0:kl10SeqPkg::numSkipFlags-1] skipFlags,
  input logic diagRead,
  input logic diagLoad,
  input logic [0:kl10SeqPkg::diagFuncW-1] diagFunc,
  input logic [0:kl10SeqPkg::ebusW-1] ebusIn,
  output logic [0:kl10SeqPkg::cramAdrW-1] cradr,
  output logic [0:kl10SeqPkg::ucodeDataW-1] ucodeData,
  output logic [0:kl10SeqPkg::ebusW-1] ebusOut,
  output logic ebusDriving
);

  cramIf cramBus ();
  diagIf diagBus ();

  // Diagnostic strobes and function code go straight to the bus
  assign diagBus.diagRead = diagRead;
  assign diagBus.diagLoad = diagLoad;
  assign diagBus.diagFunc = diagFunc;
  assign diagBus.ebusIn = ebusIn;

  // Datapath field of the current microword
  assign ucodeData = cramBus.ucodeData;

  crm uCrm (
    .eboxClk(eboxClk),
    .cradr(cradr),
    .cram(cramBus)
  );

  cra uCra (
    .eboxClk(eboxClk),
    .rstN(rstN),
    .force1777(force1777),
    .dramA(dramA),
    .dramJ(dramJ),
    .flagGroups(flagGroups),
    .skipFlags(skipFlags),
    .cram(cramBus),
    .diag(diagBus),
    .cradr(cradr),
    .ebusOut(ebusOut),
    .ebusDriving(ebusDriving)
  );

endmodule

`default_nettype wire

/* verilog/sbrStack.sv */
`default_nettype none

module sbrStack (
  input logic eboxClk,
  input logic rstN,
  input logic clear,
  input logic push,
  input logic pop,
  input logic [0:kl10SeqPkg::cramAdrW-1] pushAdr,
  output logic [0:kl10SeqPkg::cramAdrW-1] stackTop,
  output logic [0:kl10SeqPkg::stackPtrW-1] stackPtr
);
  import kl10SeqPkg::*;

  logic [0:cramAdrW-1] entries [stackDepth];
  logic [0:stackPtrW-1] nextPtr;

  // Pop first, so a call in a return word reuses the popped slot
  always_comb begin
    nextPtr = stackPtr;
    if (pop) begin
      nextPtr = nextPtr - 1'b1;
    end
    if (push) begin
      nextPtr = nextPtr + 1'b1;
    end
  end

  // Pointer wraps in both directions
  always_ff @(posedge eboxClk) begin
    if (!rstN || clear) begin
      stackPtr <= '0;
    end else begin
      stackPtr <= nextPtr;
    end
  end

  always_ff @(posedge eboxClk) begin
    if (push) begin
      entries[nextPtr] <= pushAdr;
    end
  end

  // Top of stack seen by a return in the current word
  assign stackTop = entries[stackPtr];

endmodule

`default_nettype wire

/* vlog.f */
verilog/kl10SeqPkg.sv
verilog/cramIf.sv
verilog/diagIf.sv
verilog/crm.sv
verilog/dispatchMux.sv
verilog/sbrStack.sv
verilog/cra.sv
verilog/microSequencer.sv
test/sbrStack_asserts.sv
test/microSequencerTb.sv
